/* hw/hexDisplayPkg.sv */
//////////////////////////////
// Hex display shared package
// Screen geometry, widths, pixel types and palette
//////////////////////////////
package hexDisplayPkg;

  // Horizontal timing in pixel clocks
  localparam int hActive  = 128;
  localparam int hFront   = 8;
  localparam int hSyncLen = 16;
  localparam int hBack    = 8;
  localparam int hTotal   = hActive + hFront + hSyncLen + hBack;

  // Vertical timing in lines
  localparam int vActive  = 16;
  localparam int vFront   = 1;
  localparam int vSyncLen = 2;
  localparam int vBack    = 1;
  localparam int vTotal   = vActive + vFront + vSyncLen + vBack;

  localparam int dataBits     = 128;
  localparam int digitsPerRow = 16;
  localparam int glyphWidth   = 5;
  localparam int fontDepth    = 128;
  // Coordinate to pixel latency
  localparam int pipeDepth    = 3;
  localparam string fontFile  = "hw/hexFont.mem";

  typedef logic [7:0]          xCoordT;
  typedef logic [4:0]          yCoordT;
  typedef logic [3:0]          hexDigitT;
  typedef logic [6:0]          fontAddrT;
  typedef logic [2:0]          glyphColT;
  typedef logic [15:0]         colorT;
  typedef logic [dataBits-1:0] hexDataT;

  localparam colorT colorWhite = 16'hFFFF;

  // RGB565 background per digit value
  localparam colorT palette [16] = '{
    16'h0000, 16'h4000, 16'h2100, 16'h4200,
    16'h0200, 16'h0208, 16'h0008, 16'h4008,
    16'h630C, 16'h8000, 16'h4200, 16'h8400,
    16'h0400, 16'h0410, 16'h0010, 16'h8010
  };

  typedef enum logic {latchIdle, latchPending} latchStateT;

endpackage

/* hw/videoTiming.sv */
//////////////////////////////
// Video raster timing
// Free-running pixel and line counters with sync decode
//////////////////////////////
`timescale 1ns/100ps

module videoTiming
  import hexDisplayPkg::*;
(
  input  logic   clk,
  input  logic   rstN,
  output xCoordT pixX,
  output yCoordT pixY,
  output logic   timActive,
  output logic   timHSync,
  output logic   timVSync,
  output logic   frameStart
);

  xCoordT hCount;
  yCoordT vCount;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      hCount <= '0;
      vCount <= '0;
    end
    else if (hCount == xCoordT'(hTotal - 1))
    begin
      hCount <= '0;
      // Line wrap advances the frame
      if (vCount == yCoordT'(vTotal - 1))
        vCount <= '0;
      else
        vCount <= vCount + 1'b1;
    end
    else
    begin
      hCount <= hCount + 1'b1;
    end
  end

  assign pixX = hCount;
  assign pixY = vCount;

  assign timActive = (hCount < xCoordT'(hActive)) && (vCount < yCoordT'(vActive));

  // Sync pulses sit after the front porch
  assign timHSync = (hCount >= xCoordT'(hActive + hFront)) &&
                    (hCount < xCoordT'(hActive + hFront + hSyncLen));
  assign timVSync = (vCount >= yCoordT'(vActive + vFront)) &&
                    (vCount < yCoordT'(vActive + vFront + vSyncLen));

  assign frameStart = (hCount == '0) && (vCount == '0);

  hCountRange: assert property (@(posedge clk) disable iff (!rstN)
    hCount < xCoordT'(hTotal));

  frameStartPulse: assert property (@(posedge clk) disable iff (!rstN)
    frameStart |=> !frameStart);

endmodule

/* hw/hexCellDecode.sv */
//////////////////////////////
// Hex cell decoder
// Frame-synchronous data latch, pixel to digit decode
//////////////////////////////
`timescale 1ns/100ps

module hexCellDecode
  import hexDisplayPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  hexDataT  hexData,
  input  logic     dataLoad,
  input  logic     frameStart,
  input  xCoordT   pixX,
  input  yCoordT   pixY,
  input  logic     timActive,
  input  logic     timHSync,
  input  logic     timVSync,
  output hexDigitT cellDigit,
  output fontAddrT fontAddr,
  output glyphColT glyphCol,
  output logic     decActive,
  output logic     decHSync,
  output logic     decVSync
);

  latchStateT latchState;
  hexDataT    pendData;
  hexDataT    shownData;
  hexDataT    curData;
  logic [4:0] digitIdx;
  logic       swapNow;

  // Last load of a frame wins
  always_ff @(posedge clk)
  begin
    if (dataLoad)
      pendData <= hexData;
  end

  assign swapNow = frameStart && (latchState == latchPending);

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      latchState <= latchIdle;
      shownData  <= '0;
    end
    else
    begin
      if (swapNow)
        shownData <= pendData;
      // A load in the swap cycle waits for the next frame
      if (dataLoad)
        latchState <= latchPending;
      else if (frameStart)
        latchState <= latchIdle;
    end
  end

  // Pixel 0,0 of a new frame already sees the new value
  assign curData = swapNow ? pendData : shownData;

  assign digitIdx = 5'((pixY >> 3) * digitsPerRow + (pixX >> 3));

  always_ff @(posedge clk)
  begin
    cellDigit <= curData[{digitIdx, 2'b00} +: 4];
    fontAddr  <= {curData[{digitIdx, 2'b00} +: 4], pixY[2:0]};
    glyphCol  <= pixX[2:0];
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      decActive <= 1'b0;
      decHSync  <= 1'b0;
      decVSync  <= 1'b0;
    end
    else
    begin
      decActive <= timActive;
      decHSync  <= timHSync;
      decVSync  <= timVSync;
    end
  end

  shownOnlyAtFrame: assert property (@(posedge clk) disable iff (!rstN)
    !frameStart |=> $stable(shownData));

endmodule

/* hw/glyphRowFetch.sv */
//////////////////////////////
// Glyph row fetch
// Font lookup and glyph pixel select
//////////////////////////////
`timescale 1ns/100ps

module glyphRowFetch
  import hexDisplayPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  fontAddrT fontAddr,
  input  glyphColT glyphCol,
  input  hexDigitT cellDigit,
  input  logic     decActive,
  input  logic     decHSync,
  input  logic     decVSync,
  output logic     pixelOn,
  output hexDigitT fetDigit,
  output logic     fetActive,
  output logic     fetHSync,
  output logic     fetVSync
);

  // Bit n of a word is glyph column n
  logic [glyphWidth-1:0] fontMem [fontDepth];

  initial
  begin
    $readmemb(fontFile, fontMem);
  end

  always_ff @(posedge clk)
  begin
    // Columns past the glyph stay dark as spacing
    if (glyphCol < glyphColT'(glyphWidth))
      pixelOn <= fontMem[fontAddr][glyphCol];
    else
      pixelOn <= 1'b0;
    fetDigit <= cellDigit;
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      fetActive <= 1'b0;
      fetHSync  <= 1'b0;
      fetVSync  <= 1'b0;
    end
    else
    begin
      fetActive <= decActive;
      fetHSync  <= decHSync;
      fetVSync  <= decVSync;
    end
  end

endmodule

/* hw/pixelColor.sv */
//////////////////////////////
// Pixel color stage
// Palette, glyph color and blanking
//////////////////////////////
`timescale 1ns/100ps

module pixelColor
  import hexDisplayPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  logic     pixelOn,
  input  hexDigitT fetDigit,
  input  logic     fetActive,
  input  logic     fetHSync,
  input  logic     fetVSync,
  output colorT    color,
  output logic     hSync,
  output logic     vSync,
  output logic     blank
);

  colorT pixColor;

  // Glyph over digit background, black outside the picture
  always_comb
  begin
    if (!fetActive)
      pixColor = '0;
    else if (pixelOn)
      pixColor = colorWhite;
    else
      pixColor = palette[fetDigit];
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      color <= '0;
      hSync <= 1'b0;
      vSync <= 1'b0;
      blank <= 1'b1;
    end
    else
    begin
      color <= pixColor;
      hSync <= fetHSync;
      vSync <= fetVSync;
      blank <= !fetActive;
    end
  end

  blankIsBlack: assert property (@(posedge clk) disable iff (!rstN)
    blank |-> (color == '0));

endmodule

/* hw/hexDisplay.sv */
//////////////////////////////
// Hex display top
// Raster, decode, font fetch and color pipeline
//////////////////////////////
`timescale 1ns/100ps

module hexDisplay
  import hexDisplayPkg::*;
(
  input  logic    clk,
  input  logic    rstN,
  input  hexDataT hexData,
  input  logic    dataLoad,
  output colorT   color,
  output logic    hSync,
  output logic    vSync,
  output logic    blank
);

  xCoordT   pixX;
  yCoordT   pixY;
  logic     timActive;
  logic     timHSync;
  logic     timVSync;
  logic     frameStart;

  hexDigitT cellDigit;
  fontAddrT fontAddr;
  glyphColT glyphCol;
  logic     decActive;
  logic     decHSync;
  logic     decVSync;

  logic     pixelOn;
  hexDigitT fetDigit;
  logic     fetActive;
  logic     fetHSync;
  logic     fetVSync;

  videoTiming i_videoTiming (
    .clk        (clk),
    .rstN       (rstN),
    .pixX       (pixX),
    .pixY       (pixY),
    .timActive  (timActive),
    .timHSync   (timHSync),
    .timVSync   (timVSync),
    .frameStart (frameStart)
  );

  hexCellDecode i_hexCellDecode (
    .clk        (clk),
    .rstN       (rstN),
    .hexData    (hexData),
    .dataLoad   (dataLoad),
    .frameStart (frameStart),
    .pixX       (pixX),
    .pixY       (pixY),
    .timActive  (timActive),
    .timHSync   (timHSync),
    .timVSync   (timVSync),
    .cellDigit  (cellDigit),
    .fontAddr   (fontAddr),
    .glyphCol   (glyphCol),
    .decActive  (decActive),
    .decHSync   (decHSync),
    .decVSync   (decVSync)
  );

  glyphRowFetch i_glyphRowFetch (
    .clk        (clk),
    .rstN       (rstN),
    .fontAddr   (fontAddr),
    .glyphCol   (glyphCol),
    .cellDigit  (cellDigit),
    .decActive  (decActive),
    .decHSync   (decHSync),
    .decVSync   (decVSync),
    .pixelOn    (pixelOn),
    .fetDigit   (fetDigit),
    .fetActive  (fetActive),
    .fetHSync   (fetHSync),
    .fetVSync   (fetVSync)
  );

  pixelColor i_pixelColor (
    .clk        (clk),
    .rstN       (rstN),
    .pixelOn    (pixelOn),
    .fetDigit   (fetDigit),
    .fetActive  (fetActive),
    .fetHSync   (fetHSync),
    .fetVSync   (fetVSync),
    .color      (color),
    .hSync      (hSync),
    .vSync      (vSync),
    .blank      (blank)
  );

endmodule

/* testbench/hexDisplayChecker.sv */
//////////////////////////////
// Hex display checker
// Rebuilds the raster from the ports, compares pixels
//////////////////////////////
`timescale 1ns/100ps

module hexDisplayChecker
  import hexDisplayPkg::*;
(
  input  logic    clk,
  input  logic    rstN,
  input  hexDataT hexData,
  input  logic    dataLoad,
  input  colorT   color,
  input  logic    hSync,
  input  logic    vSync,
  input  logic    blank,
  output int      checkCount,
  output int      errorCount
);

  logic [glyphWidth-1:0] font [fontDepth];

  // RGB565 background for each digit value
  colorT bgColor [16] = '{
    16'h0000, 16'h4000, 16'h2100, 16'h4200,
    16'h0200, 16'h0208, 16'h0008, 16'h4008,
    16'h630C, 16'h8000, 16'h4200, 16'h8400,
    16'h0400, 16'h0410, 16'h0010, 16'h8010
  };

  hexDataT shownData;
  hexDataT pendData;
  colorT   expColor;
  logic    resetSeen;
  logic    hSyncPrev;
  logic    vSyncPrev;
  logic    hSyncSeen;
  logic    vSyncSeen;
  int      xCount;
  int      lineCount;
  int      hPeriod;
  int      vPeriod;
  int      hHigh;
  int      vHigh;

  initial
  begin
    checkCount = 0;
    errorCount = 0;
    $readmemb(fontFile, font);
  end

  // Expected color of pixel x, y for a given register value
  function automatic colorT expectedPixel(input hexDataT data, input int x, input int y);
    int                    idx;
    hexDigitT              digit;
    logic [2:0]            row;
    logic [2:0]            col;
    logic [glyphWidth-1:0] word;
    idx   = (y / 8) * 16 + x / 8;
    digit = hexDigitT'(data >> (4 * idx));
    row   = 3'(y % 8);
    col   = 3'(x % 8);
    word  = font[{digit, row}];
    if (col < 3'd5 && word[col])
      return 16'hFFFF;
    return bgColor[digit];
  endfunction

  task automatic reportError(input string msg);
    errorCount++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  always @(posedge clk)
  begin
    if (!rstN)
    begin
      resetSeen = 1'b0;
      shownData = '0;
      pendData  = '0;
      hSyncPrev = 1'b0;
      vSyncPrev = 1'b0;
      hSyncSeen = 1'b0;
      vSyncSeen = 1'b0;
      xCount    = 0;
      lineCount = 0;
      hPeriod   = 0;
      vPeriod   = 0;
      hHigh     = 0;
      vHigh     = 0;
    end
    else
    begin
      // Outputs still carry their reset values here
      if (!resetSeen)
      begin
        resetSeen = 1'b1;
        checkCount++;
        if (blank !== 1'b1 || color !== '0 || hSync !== 1'b0 || vSync !== 1'b0)
          reportError($sformatf("outputs after reset: blank %b color %h hSync %b vSync %b",
                                blank, color, hSync, vSync));
      end
      if (dataLoad)
        pendData = hexData;

      checkCount++;
      if (blank)
      begin
        if (color !== '0)
          reportError($sformatf("color %h while blanked", color));
      end
      else
      begin
        expColor = expectedPixel(shownData, xCount, lineCount);
        if (color !== expColor)
          reportError($sformatf("pixel x %0d y %0d expected %h actual %h",
                                xCount, lineCount, expColor, color));
        xCount++;
      end

      hPeriod++;
      vPeriod++;
      if (hSync)
        hHigh++;
      if (vSync)
        vHigh++;

      // End of a line
      if (hSync && !hSyncPrev)
      begin
        checkCount++;
        if (hSyncSeen && hPeriod != hTotal)
          reportError($sformatf("hSync period %0d cycles, expected %0d", hPeriod, hTotal));
        if (xCount != 0 && xCount != hActive)
          reportError($sformatf("line %0d has %0d active pixels", lineCount, xCount));
        if (xCount != 0)
          lineCount++;
        xCount    = 0;
        hPeriod   = 0;
        hSyncSeen = 1'b1;
      end
      if (!hSync && hSyncPrev)
      begin
        if (hHigh != hSyncLen)
          reportError($sformatf("hSync high for %0d cycles", hHigh));
        hHigh = 0;
      end

      // End of a frame, loaded data shows from the next one
      if (vSync && !vSyncPrev)
      begin
        checkCount++;
        if (vSyncSeen && vPeriod != hTotal * vTotal)
          reportError($sformatf("vSync period %0d cycles", vPeriod));
        if (lineCount != vActive)
          reportError($sformatf("frame has %0d active lines", lineCount));
        lineCount = 0;
        vPeriod   = 0;
        vSyncSeen = 1'b1;
        shownData = pendData;
      end
      if (!vSync && vSyncPrev)
      begin
        if (vHigh != vSyncLen * hTotal)
          reportError($sformatf("vSync high for %0d cycles", vHigh));
        vHigh = 0;
      end

      hSyncPrev = hSync;
      vSyncPrev = vSync;
    end
  end

endmodule

/* testbench/tbHexDisplay.sv */
//////////////////////////////
// Hex display testbench
// Clock, reset, data loads and test sequence
//////////////////////////////
`timescale 1ns/100ps

module tbHexDisplay
  import hexDisplayPkg::*;
();

  logic    clk;
  logic    rstN;
  hexDataT hexData;
  logic    dataLoad;
  colorT   color;
  logic    hSync;
  logic    vSync;
  logic    blank;
  int      checkCount;
  int      errorCount;
  int      testsRun;
  int      testsFailed;
  int      errBefore;
  int      checksBefore;

  hexDisplay i_hexDisplay (
    .clk      (clk),
    .rstN     (rstN),
    .hexData  (hexData),
    .dataLoad (dataLoad),
    .color    (color),
    .hSync    (hSync),
    .vSync    (vSync),
    .blank    (blank)
  );

  hexDisplayChecker i_hexDisplayChecker (
    .clk        (clk),
    .rstN       (rstN),
    .hexData    (hexData),
    .dataLoad   (dataLoad),
    .color      (color),
    .hSync      (hSync),
    .vSync      (vSync),
    .blank      (blank),
    .checkCount (checkCount),
    .errorCount (errorCount)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $finish;
  endtask

  // Waits for vSync to change to the given level
  task automatic waitVSyncEdge(input logic level);
    int   cycles;
    logic prev;
    cycles = 0;
    prev   = vSync;
    @(negedge clk);
    while (!(vSync == level && prev != level))
    begin
      if (cycles > hTotal * vTotal + hTotal)
        failRun($sformatf("Timeout: vSync did not go to %b within %0d cycles", level, cycles));
      prev = vSync;
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic waitBlankFall();
    int   cycles;
    logic prev;
    cycles = 0;
    prev   = blank;
    @(negedge clk);
    while (!(prev && !blank))
    begin
      if (cycles > hTotal * vTotal)
        failRun($sformatf("Timeout: no active pixel within %0d cycles", cycles));
      prev = blank;
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic loadValue(input hexDataT value);
    hexData  = value;
    dataLoad = 1'b1;
    @(negedge clk);
    dataLoad = 1'b0;
  endtask

  // Load some cycles after the first active pixel of a frame
  task automatic loadInFrame(input hexDataT value, input int delay);
    waitVSyncEdge(1'b0);
    waitBlankFall();
    repeat (delay) @(negedge clk);
    loadValue(value);
  endtask

  function automatic hexDataT randomData();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic beginTest();
    errBefore    = errorCount;
    checksBefore = checkCount;
  endtask

  task automatic endTest(input string name);
    testsRun++;
    if (errorCount != errBefore)
    begin
      testsFailed++;
      $display("Test %s: failed with %0d errors", name, errorCount - errBefore);
    end
    else if (checkCount == checksBefore)
    begin
      testsFailed++;
      $display("Test %s: failed because no checks ran", name);
    end
    else
    begin
      $display("Test %s: passed, %0d checks", name, checkCount - checksBefore);
    end
  endtask

  initial
  begin
    rstN        = 1'b0;
    hexData     = '0;
    dataLoad    = 1'b0;
    testsRun    = 0;
    testsFailed = 0;
    void'($urandom(28));
    repeat (5) @(negedge clk);

    beginTest();
    rstN = 1'b1;
    @(negedge clk);
    endTest("1 reset state");

    beginTest();
    repeat (3) waitVSyncEdge(1'b1);
    endTest("2 sync geometry");

    // Digits 0 to F in every text row
    beginTest();
    loadInFrame({2{64'hFEDCBA9876543210}}, 100);
    repeat (2) waitVSyncEdge(1'b1);
    endTest("3 fixed pattern");

    beginTest();
    loadInFrame(randomData(), 1200);
    repeat (2) waitVSyncEdge(1'b1);
    loadInFrame(randomData(), 300);
    repeat (600) @(negedge clk);
    loadValue(randomData());
    repeat (2) waitVSyncEdge(1'b1);
    endTest("4 mid-frame and double load");

    beginTest();
    for (int i = 0; i < 8; i++)
    begin
      loadInFrame(randomData(), $urandom % 2300);
      waitVSyncEdge(1'b1);
    end
    waitVSyncEdge(1'b1);
    endTest("5 random frames");

    beginTest();
    repeat (3) waitVSyncEdge(1'b1);
    endTest("6 blanking");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, checkCount, errorCount);
    if (testsFailed == 0 && errorCount == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* project.f */
hw/hexDisplayPkg.sv
hw/videoTiming.sv
hw/hexCellDecode.sv
hw/glyphRowFetch.sv
hw/pixelColor.sv
hw/hexDisplay.sv
testbench/hexDisplayChecker.sv
testbench/tbHexDisplay.sv

/* build.sh */
#!/bin/sh
# Compile and run the hex display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module tbHexDisplay \
  -Mdir obj_dir \
  -o simHexDisplay

./obj_dir/simHexDisplay > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

/* hw/hexFont.mem */
// Hex font, 8 rows per glyph for digits 0 to F, address is digit*8 + row
// Each word is 5 bits, the rightmost bit is glyph column 0 (left edge)
01110
10001
11001
10101
10011
10001
01110
00000
00100
00110
00100
00100
00100
00100
01110
00000
01110
10001
10000
01000
00100
00010
11111
00000
11111
01000
00100
01000
10000
10001
01110
00000
01000
01100
01010
01001
11111
01000
01000
00000
11111
00001
01111
10000
10000
10001
01110
00000
01100
00010
00001
01111
10001
10001
01110
00000
11111
10000
01000
00100
00010
00010
00010
00000
01110
10001
10001
01110
10001
10001
01110
00000
01110
10001
10001
11110
10000
01000
00110
00000
01110
10001
10001
11111
10001
10001
10001
00000
01111
10001
10001
01111
10001
10001
01111
00000
01110
10001
00001
00001
00001
10001
01110
00000
01111
10001
10001
10001
10001
10001
01111
00000
11111
00001
00001
01111
00001
00001
11111
00000
11111
00001
00001
01111
00001
00001
00001
00000
